// ==== Bender.yml ====
package:
  name: tage_predictor

sources:
  - hdl/tagePkg.sv
  - hdl/tageHashPkg.sv
  - hdl/tageControl.sv
  - hdl/baseBank.sv
  - hdl/taggedBank.sv
  - hdl/providerSelect.sv
  - hdl/tagePredictor.sv
  - target: test
    include_dirs:
      - test
    files:
      - test/tagePredictorTb.sv

// ==== hdl/baseBank.sv ====
`timescale 1ns/1ps
`default_nettype none

module baseBank #(
    parameter int indexWidth = 7
) (
    input  logic                        Clk,
    input  logic                        rstN,
    input  logic [tagePkg::pcWidth-1:0] lookupPc,
    input  logic [tagePkg::pcWidth-1:0] updPc,
    input  logic                        baseWrite,
    input  logic                        updTaken,
    input  tagePkg::ctrT                updCounterNew,
    output tagePkg::ctrT                baseCounter
);
    localparam int depth = 1 << indexWidth;

    tagePkg::ctrT          ctrs [depth];
    logic [indexWidth-1:0] lookupIdx;
    logic [indexWidth-1:0] updIdx;

    // PC only, no history
    assign lookupIdx = indexWidth'(tageHashPkg::foldIndex(lookupPc, '0, 0, indexWidth));
    assign updIdx    = indexWidth'(tageHashPkg::foldIndex(updPc, '0, 0, indexWidth));

    always_ff @(posedge Clk) begin
        if (!rstN) begin
            for (int i = 0; i < depth; i++) begin
                ctrs[i] <= tagePkg::baseReset;
            end
        end else if (baseWrite) begin
            ctrs[updIdx] <= updCounterNew;
        end
    end

    always_ff @(posedge Clk) begin
        baseCounter <= ctrs[lookupIdx];   // old data on a same-cycle write
    end

    // the trained value must have moved toward the resolved outcome
    trainDirection: assert property (@(posedge Clk) disable iff (!rstN)
        baseWrite |-> updCounterNew != (updTaken ? 2'd0 : 2'd3))
        else $error("base counter trained against the outcome");

endmodule

`default_nettype wire

// ==== hdl/providerSelect.sv ====
`timescale 1ns/1ps
`default_nettype none

module providerSelect (
    input  logic                                  Clk,
    input  logic                                  rstN,
    input  logic                                  stageValid,
    input  logic [tagePkg::numTagged-1:0]         hits,
    input  tagePkg::ctrT [tagePkg::numTagged-1:0] bankCounters,
    input  tagePkg::ctrT                          baseCounter,
    output logic                                  outTaken,
    output tagePkg::bankT                         outProvider,
    output tagePkg::ctrT                          outCounter,
    output logic                                  outAltTaken,
    output tagePkg::bankT                         outAltProvider,
    output tagePkg::ctrT                          outAltCounter
);
    tagePkg::bankT provBank;
    tagePkg::ctrT  provCtr;
    tagePkg::bankT altBank;
    tagePkg::ctrT  altCtr;

    // walk up the banks, each hit pushes the previous provider down to alternate
    always_comb begin
        provBank = '0;
        provCtr  = baseCounter;
        altBank  = '0;
        altCtr   = baseCounter;
        for (int i = 0; i < tagePkg::numTagged; i++) begin
            if (hits[i]) begin
                altBank  = provBank;
                altCtr   = provCtr;
                provBank = tagePkg::bankT'(i + 1);
                provCtr  = bankCounters[i];
            end
        end
    end

    always_ff @(posedge Clk) begin
        if (!rstN) begin
            outTaken       <= 1'b0;
            outProvider    <= '0;
            outCounter     <= '0;
            outAltTaken    <= 1'b0;
            outAltProvider <= '0;
            outAltCounter  <= '0;
        end else if (stageValid) begin   // hold last result between lookups
            outTaken       <= provCtr[1];
            outProvider    <= provBank;
            outCounter     <= provCtr;
            outAltTaken    <= altCtr[1];
            outAltProvider <= altBank;
            outAltCounter  <= altCtr;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/tageControl.sv ====
`timescale 1ns/1ps
`default_nettype none

module tageControl (
    input  logic                          Clk,
    input  logic                          rstN,
    input  logic                          predValid,
    input  logic [tagePkg::pcWidth-1:0]   predPc,
    input  logic                          predBranch,
    input  logic                          outTaken,
    input  logic                          updValid,
    input  logic [tagePkg::ghrWidth-1:0]  updGhr,
    input  logic                          updTaken,
    input  logic                          updPredTaken,
    input  tagePkg::bankT                 updProvider,
    input  tagePkg::ctrT                  updCounter,
    output logic [tagePkg::ghrWidth-1:0]  lookupGhr,
    output logic                          stageValid,
    output logic                          outValid,
    output logic [tagePkg::ghrWidth-1:0]  outGhr,
    output logic [tagePkg::pcWidth-1:0]   outPc,
    output tagePkg::ctrT                  updCounterNew,
    output logic                          baseWrite,
    output logic [tagePkg::numTagged-1:0] bankTrain,
    output logic [tagePkg::numTagged-1:0] bankAlloc
);
    logic [tagePkg::ghrWidth-1:0] ghr;
    logic [tagePkg::ghrWidth-1:0] stageGhr;
    logic [tagePkg::pcWidth-1:0]  stagePc;
    logic                         stageBranch;
    logic                         outBranch;
    logic                         mispredict;

    assign lookupGhr  = ghr;               // every bank hashes the same snapshot
    assign mispredict = updValid && (updTaken != updPredTaken);

    // speculative history where a mispredict restore overrides the shift
    always_ff @(posedge Clk) begin
        if (!rstN) begin
            ghr <= '0;
        end else if (mispredict) begin
            ghr <= {updGhr[tagePkg::ghrWidth-2:0], updTaken};
        end else if (outValid && outBranch) begin
            ghr <= {ghr[tagePkg::ghrWidth-2:0], outTaken};
        end
    end

    always_ff @(posedge Clk) begin
        if (!rstN) begin
            stageValid <= 1'b0;
            outValid   <= 1'b0;
        end else begin
            stageValid <= predValid;
            outValid   <= stageValid;
        end
    end

    always_ff @(posedge Clk) begin
        stagePc     <= predPc;
        stageGhr    <= ghr;
        stageBranch <= predBranch;
        outPc       <= stagePc;
        outGhr      <= stageGhr;           // history the lookup was hashed with
        outBranch   <= stageBranch;
    end

    always_comb begin
        updCounterNew = updCounter;
        if (updTaken && updCounter != 2'd3) begin
            updCounterNew = updCounter + 2'd1;
        end else if (!updTaken && updCounter != 2'd0) begin
            updCounterNew = updCounter - 2'd1;
        end
    end

    assign baseWrite = updValid && (updProvider == '0);

    // provider trains and the next longer bank allocates on a mispredict
    always_comb begin
        for (int i = 0; i < tagePkg::numTagged; i++) begin
            bankTrain[i] = updValid && (updProvider == tagePkg::bankT'(i + 1));
            bankAlloc[i] = mispredict && (updProvider == tagePkg::bankT'(i));
        end
    end

    providerInRange: assert property (@(posedge Clk) disable iff (!rstN)
        updValid |-> updProvider <= tagePkg::bankT'(tagePkg::numTagged))
        else $error("update names provider bank %0d that does not exist", updProvider);

endmodule

`default_nettype wire

// ==== hdl/tageHashPkg.sv ====
`default_nettype none

package tageHashPkg;

    localparam int pcDropBits = 3;         // fetch block offset bits
    localparam int maxFoldW   = 16;        // widest index or tag a bank may ask for

    // PC above pcDropBits folded into width-bit chunks, xored with the
    // newest histLen history bits folded the same way
    function automatic logic [maxFoldW-1:0] foldIndex(
        input logic [tagePkg::pcWidth-1:0]  pc,
        input logic [tagePkg::ghrWidth-1:0] ghr,
        input int                           histLen,
        input int                           width
    );
        logic [maxFoldW-1:0] res;
        res = '0;
        for (int i = 0; i < tagePkg::pcWidth - pcDropBits; i++) begin
            res[i % width] = res[i % width] ^ pc[i + pcDropBits];
        end
        for (int i = 0; i < tagePkg::ghrWidth; i++) begin
            if (i < histLen) begin
                res[i % width] = res[i % width] ^ ghr[i];   // bit 0 is the newest outcome
            end
        end
        return res;
    endfunction

    function automatic logic [maxFoldW-1:0] foldTag(
        input logic [tagePkg::pcWidth-1:0] pc,
        input tagePkg::bankT               bankNum,
        input int                          width
    );
        logic [maxFoldW-1:0] res;
        res = '0;
        for (int i = 0; i < tagePkg::pcWidth - pcDropBits; i++) begin
            res[i % width] = res[i % width] ^ pc[i + pcDropBits];
        end
        res = res ^ maxFoldW'(bankNum);    // keeps equal-width banks apart
        return res;
    endfunction

endpackage

`default_nettype wire

// ==== hdl/tagePkg.sv ====
`default_nettype none

package tagePkg;

    localparam int pcWidth   = 32;
    localparam int ghrWidth  = 16;         // longest history slice of any bank
    localparam int numTagged = 4;

    // 2-bit saturating direction counter, upper bit set means taken
    typedef logic [1:0] ctrT;

    // 0 is the base table, 1..numTagged the tagged banks
    typedef logic [2:0] bankT;

    localparam ctrT weakNotTaken = 2'd1;
    localparam ctrT weakTaken    = 2'd2;   // written on allocation
    localparam ctrT baseReset    = weakNotTaken;

endpackage

`default_nettype wire

// ==== hdl/tagePredictor.sv ====
`timescale 1ns/1ps
`default_nettype none

module tagePredictor #(
    parameter int indexWidth                     = 7,
    parameter int histLens  [tagePkg::numTagged] = '{2, 4, 8, 16},
    parameter int tagWidths [tagePkg::numTagged] = '{7, 7, 8, 8}
) (
    input  logic                         Clk,
    input  logic                         rstN,
    input  logic                         predValid,
    input  logic [tagePkg::pcWidth-1:0]  predPc,
    input  logic                         predBranch,
    input  logic                         updValid,
    input  logic [tagePkg::pcWidth-1:0]  updPc,
    input  logic [tagePkg::ghrWidth-1:0] updGhr,
    input  logic                         updTaken,
    input  logic                         updPredTaken,
    input  tagePkg::bankT                updProvider,
    input  tagePkg::ctrT                 updCounter,
    output logic                         outValid,
    output logic                         outTaken,
    output tagePkg::bankT                outProvider,
    output tagePkg::ctrT                 outCounter,
    output logic                         outAltTaken,
    output tagePkg::bankT                outAltProvider,
    output tagePkg::ctrT                 outAltCounter,
    output logic [tagePkg::ghrWidth-1:0] outGhr,
    output logic [tagePkg::pcWidth-1:0]  outPc
);
    logic [tagePkg::ghrWidth-1:0]          lookupGhr;
    logic                                  stageValid;
    tagePkg::ctrT                          updCounterNew;
    logic                                  baseWrite;
    logic [tagePkg::numTagged-1:0]         bankTrain;
    logic [tagePkg::numTagged-1:0]         bankAlloc;
    logic [tagePkg::numTagged-1:0]         hits;
    tagePkg::ctrT [tagePkg::numTagged-1:0] bankCounters;
    tagePkg::ctrT                          baseCounter;

    tageControl control (
        .Clk           (Clk),
        .rstN          (rstN),
        .predValid     (predValid),
        .predPc        (predPc),
        .predBranch    (predBranch),
        .outTaken      (outTaken),
        .updValid      (updValid),
        .updGhr        (updGhr),
        .updTaken      (updTaken),
        .updPredTaken  (updPredTaken),
        .updProvider   (updProvider),
        .updCounter    (updCounter),
        .lookupGhr     (lookupGhr),
        .stageValid    (stageValid),
        .outValid      (outValid),
        .outGhr        (outGhr),
        .outPc         (outPc),
        .updCounterNew (updCounterNew),
        .baseWrite     (baseWrite),
        .bankTrain     (bankTrain),
        .bankAlloc     (bankAlloc)
    );

    baseBank #(
        .indexWidth (indexWidth)
    ) base (
        .Clk           (Clk),
        .rstN          (rstN),
        .lookupPc      (predPc),
        .updPc         (updPc),
        .baseWrite     (baseWrite),
        .updTaken      (updTaken),
        .updCounterNew (updCounterNew),
        .baseCounter   (baseCounter)
    );

    // bank g+1 uses the g-th history length and tag width
    for (genvar g = 0; g < tagePkg::numTagged; g++) begin : genBank
        taggedBank #(
            .indexWidth (indexWidth),
            .histLen    (histLens[g]),
            .tagWidth   (tagWidths[g]),
            .bankNum    (tagePkg::bankT'(g + 1))
        ) bank (
            .Clk           (Clk),
            .rstN          (rstN),
            .lookupPc      (predPc),
            .lookupGhr     (lookupGhr),
            .updPc         (updPc),
            .updGhr        (updGhr),
            .updTaken      (updTaken),
            .bankTrain     (bankTrain[g]),
            .bankAlloc     (bankAlloc[g]),
            .updCounterNew (updCounterNew),
            .hit           (hits[g]),
            .counter       (bankCounters[g])
        );
    end

    providerSelect select (
        .Clk            (Clk),
        .rstN           (rstN),
        .stageValid     (stageValid),
        .hits           (hits),
        .bankCounters   (bankCounters),
        .baseCounter    (baseCounter),
        .outTaken       (outTaken),
        .outProvider    (outProvider),
        .outCounter     (outCounter),
        .outAltTaken    (outAltTaken),
        .outAltProvider (outAltProvider),
        .outAltCounter  (outAltCounter)
    );

endmodule

`default_nettype wire

// ==== hdl/taggedBank.sv ====
`timescale 1ns/1ps
`default_nettype none

module taggedBank #(
    parameter int            indexWidth = 7,
    parameter int            histLen    = 2,
    parameter int            tagWidth   = 7,
    parameter tagePkg::bankT bankNum    = 3'd1
) (
    input  logic                         Clk,
    input  logic                         rstN,
    input  logic [tagePkg::pcWidth-1:0]  lookupPc,
    input  logic [tagePkg::ghrWidth-1:0] lookupGhr,
    input  logic [tagePkg::pcWidth-1:0]  updPc,
    input  logic [tagePkg::ghrWidth-1:0] updGhr,
    input  logic                         updTaken,
    input  logic                         bankTrain,
    input  logic                         bankAlloc,
    input  tagePkg::ctrT                 updCounterNew,
    output logic                         hit,
    output tagePkg::ctrT                 counter
);
    localparam int depth = 1 << indexWidth;

    logic [depth-1:0]      valid;
    logic [tagWidth-1:0]   tags [depth];
    tagePkg::ctrT          ctrs [depth];
    logic [indexWidth-1:0] lookupIdx;
    logic [tagWidth-1:0]   lookupTag;
    logic [indexWidth-1:0] updIdx;
    logic [tagWidth-1:0]   updTag;
    logic                  validQ;
    logic [tagWidth-1:0]   tagQ;
    logic [tagWidth-1:0]   lookupTagQ;

    assign lookupIdx = indexWidth'(tageHashPkg::foldIndex(lookupPc, lookupGhr, histLen,
                                                          indexWidth));
    assign lookupTag = tagWidth'(tageHashPkg::foldTag(lookupPc, bankNum, tagWidth));
    assign updIdx    = indexWidth'(tageHashPkg::foldIndex(updPc, updGhr, histLen, indexWidth));
    assign updTag    = tagWidth'(tageHashPkg::foldTag(updPc, bankNum, tagWidth));

    always_ff @(posedge Clk) begin
        if (!rstN) begin
            valid  <= '0;
            validQ <= 1'b0;
        end else begin
            validQ <= valid[lookupIdx];
            if (bankAlloc) begin
                valid[updIdx] <= 1'b1;
            end
        end
    end

    always_ff @(posedge Clk) begin
        tagQ       <= tags[lookupIdx];
        counter    <= ctrs[lookupIdx];
        lookupTagQ <= lookupTag;            // compared against the entry next cycle
        if (bankAlloc) begin
            tags[updIdx] <= updTag;
            ctrs[updIdx] <= updTaken ? tagePkg::weakTaken : tagePkg::weakNotTaken;
        end else if (bankTrain) begin
            ctrs[updIdx] <= updCounterNew;  // tag and valid untouched
        end
    end

    assign hit = validQ && (tagQ == lookupTagQ);

    trainOrAlloc: assert property (@(posedge Clk) disable iff (!rstN)
        !(bankTrain && bankAlloc))
        else $error("bank %0d trained and allocated together", bankNum);

endmodule

`default_nettype wire

// ==== sim.f ====
+incdir+test
hdl/tagePkg.sv
hdl/tageHashPkg.sv
hdl/tageControl.sv
hdl/baseBank.sv
hdl/taggedBank.sv
hdl/providerSelect.sv
hdl/tagePredictor.sv
test/tagePredictorTb.sv

// ==== test/tageModel.svh ====
`ifndef tageModelSvh
`define tageModelSvh

// reference tables and history, stepped in the same order as the stimulus table
localparam int modelIdxW = 7;

tagePkg::ctrT                 refBase  [1 << modelIdxW];
logic [(1 << modelIdxW)-1:0]  refValid [tagePkg::numTagged];
logic [15:0]                  refTag   [tagePkg::numTagged][1 << modelIdxW];
tagePkg::ctrT                 refCtr   [tagePkg::numTagged][1 << modelIdxW];
logic [tagePkg::ghrWidth-1:0] refGhr;

function automatic int histOf(input int b);    // b counts tagged banks from 0
    return (b == 0) ? 2 : (b == 1) ? 4 : (b == 2) ? 8 : 16;
endfunction

function automatic logic [modelIdxW-1:0] baseSlot(input logic [31:0] pc);
    return modelIdxW'(tageHashPkg::foldIndex(pc, '0, 0, modelIdxW));
endfunction

function automatic logic [modelIdxW-1:0] slotOf(input logic [31:0] pc, input logic [15:0] ghr,
                                                input int b);
    return modelIdxW'(tageHashPkg::foldIndex(pc, ghr, histOf(b), modelIdxW));
endfunction

function automatic logic [15:0] tagOf(input logic [31:0] pc, input int b);
    return tageHashPkg::foldTag(pc, tagePkg::bankT'(b + 1), (b < 2) ? 7 : 8);
endfunction

function automatic tagePkg::ctrT satCounter(input tagePkg::ctrT c, input logic taken);
    if (taken) begin
        return (c == 2'd3) ? c : c + 2'd1;
    end
    return (c == 2'd0) ? c : c - 2'd1;
endfunction

task automatic clearTables();
    refGhr = '0;
    for (int b = 0; b < tagePkg::numTagged; b++) begin
        refValid[b] = '0;
    end
    foreach (refBase[i]) begin
        refBase[i] = tagePkg::baseReset;
    end
endtask

task automatic lookupTables(input logic [31:0] pc, input logic [15:0] ghr,
                            output tagePkg::bankT prov, output tagePkg::ctrT provCtr,
                            output tagePkg::bankT alt, output tagePkg::ctrT altCtr);
    logic [modelIdxW-1:0] slot;
    prov    = '0;
    alt     = '0;
    provCtr = refBase[baseSlot(pc)];
    altCtr  = provCtr;
    // longest history first, first hit provides and the second one is the alternate
    for (int b = tagePkg::numTagged - 1; b >= 0; b--) begin
        slot = slotOf(pc, ghr, b);
        if (refValid[b][slot] && refTag[b][slot] == tagOf(pc, b)) begin
            if (prov == 0) begin
                prov    = tagePkg::bankT'(b + 1);
                provCtr = refCtr[b][slot];
            end else if (alt == 0) begin
                alt    = tagePkg::bankT'(b + 1);
                altCtr = refCtr[b][slot];
            end
        end
    end
endtask

task automatic predictStep(input logic [31:0] pc, input logic branch,
                           output logic [15:0] ghrSnap,
                           output tagePkg::bankT prov, output tagePkg::ctrT provCtr,
                           output tagePkg::bankT alt, output tagePkg::ctrT altCtr);
    ghrSnap = refGhr;
    lookupTables(pc, refGhr, prov, provCtr, alt, altCtr);
    if (branch) begin
        refGhr = {refGhr[14:0], provCtr[1]};   // speculative shift of the prediction
    end
endtask

task automatic trainTables(input logic [31:0] pc, input logic [15:0] ghr, input logic taken,
                           input logic predTaken, input tagePkg::bankT prov,
                           input tagePkg::ctrT ctr);
    logic [modelIdxW-1:0] slot;
    int                   p;
    p = int'(prov);
    if (p == 0) begin
        refBase[baseSlot(pc)] = satCounter(ctr, taken);
    end else begin
        refCtr[p-1][slotOf(pc, ghr, p - 1)] = satCounter(ctr, taken);
    end
    if (taken != predTaken) begin
        if (p < tagePkg::numTagged) begin   // next longer bank has array index p
            slot              = slotOf(pc, ghr, p);
            refValid[p][slot] = 1'b1;
            refTag[p][slot]   = tagOf(pc, p);
            refCtr[p][slot]   = taken ? tagePkg::weakTaken : tagePkg::weakNotTaken;
        end
        refGhr = {ghr[14:0], taken};
    end
endtask

`endif

// ==== test/tagePredictorTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module tagePredictorTb;

    localparam int timeoutCycles = 20;

    typedef enum logic {stepPredict, stepUpdate} stepKindT;

    // predict steps carry expected outputs, update steps the fields to drive
    typedef struct packed {
        stepKindT                     kind;
        logic [tagePkg::pcWidth-1:0]  pc;
        logic                         branch;
        logic                         taken;
        logic [tagePkg::ghrWidth-1:0] ghr;      // updGhr or expected outGhr
        logic                         predTaken;
        tagePkg::bankT                prov;
        tagePkg::ctrT                 ctr;
        tagePkg::bankT                alt;
        tagePkg::ctrT                 altCtr;
    } stepT;

    logic                         Clk;
    logic                         rstN;
    logic                         predValid;
    logic [tagePkg::pcWidth-1:0]  predPc;
    logic                         predBranch;
    logic                         updValid;
    logic [tagePkg::pcWidth-1:0]  updPc;
    logic [tagePkg::ghrWidth-1:0] updGhr;
    logic                         updTaken;
    logic                         updPredTaken;
    tagePkg::bankT                updProvider;
    tagePkg::ctrT                 updCounter;
    logic                         outValid;
    logic                         outTaken;
    tagePkg::bankT                outProvider;
    tagePkg::ctrT                 outCounter;
    logic                         outAltTaken;
    tagePkg::bankT                outAltProvider;
    tagePkg::ctrT                 outAltCounter;
    logic [tagePkg::ghrWidth-1:0] outGhr;
    logic [tagePkg::pcWidth-1:0]  outPc;

    stepT        steps [$];
    int          errorCount;
    int          checkCount;
    int          stepNo;
    logic [31:0] pcA;
    logic [31:0] pcB;
    logic [31:0] pcC;
    logic [31:0] pcE;

    `include "tageModel.svh"

    tagePredictor UUT (
        .Clk(Clk), .rstN(rstN),
        .predValid(predValid), .predPc(predPc), .predBranch(predBranch),
        .updValid(updValid), .updPc(updPc), .updGhr(updGhr), .updTaken(updTaken),
        .updPredTaken(updPredTaken), .updProvider(updProvider), .updCounter(updCounter),
        .outValid(outValid), .outTaken(outTaken), .outProvider(outProvider),
        .outCounter(outCounter), .outAltTaken(outAltTaken), .outAltProvider(outAltProvider),
        .outAltCounter(outAltCounter), .outGhr(outGhr), .outPc(outPc)
    );

    always #5 Clk = ~Clk;

    task automatic checkCtr(input tagePkg::ctrT got, input tagePkg::ctrT exp, input string what);
        checkCount++;
        if (got !== exp) begin
            errorCount++;
            $display("Error at %0t ns: step %0d %s is %0d, expected %0d", $time, stepNo, what,
                     got, exp);
        end
    endtask

    task automatic checkBank(input tagePkg::bankT got, input tagePkg::bankT exp,
                             input string what);
        checkCount++;
        if (got !== exp) begin
            errorCount++;
            $display("Error at %0t ns: step %0d %s is bank %0d, expected bank %0d", $time,
                     stepNo, what, got, exp);
        end
    endtask

    task automatic checkBit(input logic got, input logic exp, input string what);
        checkCount++;
        if (got !== exp) begin
            errorCount++;
            $display("Error at %0t ns: step %0d %s is %b, expected %b", $time, stepNo, what,
                     got, exp);
        end
    endtask

    task automatic checkGhr(input logic [tagePkg::ghrWidth-1:0] got,
                            input logic [tagePkg::ghrWidth-1:0] exp);
        checkCount++;
        if (got !== exp) begin
            errorCount++;
            $display("Error at %0t ns: step %0d outGhr is %h, expected %h", $time, stepNo,
                     got, exp);
        end
    endtask

    task automatic checkPc(input logic [tagePkg::pcWidth-1:0] got,
                           input logic [tagePkg::pcWidth-1:0] exp);
        checkCount++;
        if (got !== exp) begin
            errorCount++;
            $display("Error at %0t ns: step %0d outPc is %h, expected %h", $time, stepNo,
                     got, exp);
        end
    endtask

    function automatic void addPredict(input logic [31:0] pc, input logic branch);
        stepT s;
        s        = '0;
        s.kind   = stepPredict;
        s.pc     = pc;
        s.branch = branch;
        steps.push_back(s);
    endfunction

    function automatic void appendUpdate(input logic [31:0] pc, input logic [15:0] ghr,
                                         input logic taken);
        stepT s;
        s       = '0;
        s.kind  = stepUpdate;
        s.pc    = pc;
        s.ghr   = ghr;
        s.taken = taken;
        steps.push_back(s);
    endfunction

    task automatic drivePredict(input stepT s);
        int cycles;
        @(posedge Clk);
        predValid  <= 1'b1;
        predPc     <= s.pc;
        predBranch <= s.branch;
        @(posedge Clk);
        predValid  <= 1'b0;
        cycles = 0;
        do begin
            @(negedge Clk);
            cycles++;
        end while (!outValid && cycles < timeoutCycles);
        if (!outValid) begin
            errorCount++;
            $display("step %0d: no prediction output appeared within %0d cycles", stepNo,
                     timeoutCycles);
        end else begin
            if (cycles != 2) begin           // counted from the edge that took predValid
                errorCount++;
                $display("Error at %0t ns: step %0d output came after %0d cycles, expected 2",
                         $time, stepNo, cycles);
            end
            checkBit(outTaken, s.ctr[1], "outTaken");
            checkBank(outProvider, s.prov, "outProvider");
            checkCtr(outCounter, s.ctr, "outCounter");
            checkBit(outAltTaken, s.altCtr[1], "outAltTaken");
            checkBank(outAltProvider, s.alt, "outAltProvider");
            checkCtr(outAltCounter, s.altCtr, "outAltCounter");
            checkGhr(outGhr, s.ghr);
            checkPc(outPc, s.pc);
        end
    endtask

    task automatic sendUpdate(input stepT s);
        @(posedge Clk);
        updValid     <= 1'b1;
        updPc        <= s.pc;
        updGhr       <= s.ghr;
        updTaken     <= s.taken;
        updPredTaken <= s.predTaken;
        updProvider  <= s.prov;
        updCounter   <= s.ctr;
        @(posedge Clk);
        updValid     <= 1'b0;
        repeat (2) @(posedge Clk);          // keep the write clear of the next lookup
    endtask

    initial begin
        stepT s;
        Clk          = 1'b0;
        rstN         = 1'b0;
        predValid    = 1'b0;
        predPc       = '0;
        predBranch   = 1'b0;
        updValid     = 1'b0;
        updPc        = '0;
        updGhr       = '0;
        updTaken     = 1'b0;
        updPredTaken = 1'b0;
        updProvider  = '0;
        updCounter   = '0;
        errorCount   = 0;
        checkCount   = 0;
        void'($urandom(16));
        pcA = $urandom;
        pcB = $urandom;
        pcC = $urandom;
        pcE = $urandom;

        addPredict(pcA, 1'b0);                   // fresh tables
        appendUpdate(pcC, 16'h0000, 1'b1);       // base counter walks up to 3
        appendUpdate(pcC, 16'h0002, 1'b1);
        appendUpdate(pcC, 16'h0002, 1'b1);
        addPredict(pcC, 1'b1);                   // taken branch shifts a one in
        addPredict(pcA, 1'b0);
        appendUpdate(pcE, 16'hffff, 1'b1);       // allocation in bank 1
        addPredict(pcE, 1'b0);
        repeat (3) begin                         // alternating outcomes climb banks 2 to 4
            appendUpdate(pcB, 16'h0000, 1'b1);
            appendUpdate(pcB, 16'h0000, 1'b0);
            addPredict(pcB, 1'b0);
        end
        appendUpdate(pcA, 16'h00a5, 1'b1);       // restore from the update history
        addPredict(pcA, 1'b0);
        repeat (4) addPredict($urandom, 1'b1);

        clearTables();
        for (int i = 0; i < steps.size(); i++) begin
            s = steps[i];
            if (s.kind == stepPredict) begin
                predictStep(s.pc, s.branch, s.ghr, s.prov, s.ctr, s.alt, s.altCtr);
            end else begin
                lookupTables(s.pc, s.ghr, s.prov, s.ctr, s.alt, s.altCtr);
                s.predTaken = s.ctr[1];
                trainTables(s.pc, s.ghr, s.taken, s.predTaken, s.prov, s.ctr);
            end
            steps[i] = s;
        end

        repeat (5) @(posedge Clk);
        rstN <= 1'b1;
        for (int i = 0; i < steps.size(); i++) begin
            stepNo = i;
            if (steps[i].kind == stepPredict) begin
                drivePredict(steps[i]);
            end else begin
                sendUpdate(steps[i]);
            end
        end

        $display("%0d errors in %0d checks", errorCount, checkCount);
        if (errorCount == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
